/* dbg_pkg.sv */
`default_nettype none

package dbg_pkg;

	// Core debug port commands
	typedef enum logic [3:0] {
		READ_REG   = 4'h0,
		WRITE_REG  = 4'h1,
		GO         = 4'h8,
		INTGO      = 4'h9,
		SINGLESTEP = 4'hA,
		STOP       = 4'hF
	} dbg_opcode_e;

	typedef enum logic [7:0] {
		GR0 = 8'd0, GR1, GR2, GR3, GR4, GR5, GR6, GR7,
		GR8, GR9, GR10, GR11, GR12, GR13, GR14, GR15,
		GR16, GR17, GR18, GR19, GR20, GR21, GR22, GR23,
		GR24, GR25, GR26, GR27, GR28, GR29, GR30, GR31,
		CPUIDR = 8'd64, TIDR, FLAGR, PCR, SPR, PSR, IOSAR, PDTR,
		KPDTR, TISR, IDTR, FI0R, FI1R, FRCLR, FRCHR,
		// Previous context
		PTIDR = 8'd128, PFLAGR, PPCR, PPSR, PPDTR
	} dbg_target_e;

	typedef struct packed {
		dbg_opcode_e opcode;
		logic [7:0]  target;
		logic [31:0] data;
	} dbg_cmd_t;

	typedef struct packed {
		logic        valid;
		logic        error;
		logic [31:0] data;
	} dbg_rsp_t;

	localparam logic [31:0] ERROR_WORD = 32'hFFFF_FFFF;

	// System registers start at 64, so index i maps to i + 32
	function automatic dbg_target_e dbg_index_to_target(input logic [5:0] index);
		if (index < 6'd32) begin
			return dbg_target_e'({2'b00, index});
		end
		return dbg_target_e'(8'd32 + {2'b00, index});
	endfunction

endpackage

`default_nettype wire

/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} uart_byte_t;

	// One word of the register dump
	typedef struct packed {
		logic [31:0] word;
		logic        first;
		logic        last;
	} fmt_req_t;

	typedef enum logic [1:0] {
		IDLE,
		START,
		HEX,
		TAIL
	} fmt_state_e;

	localparam logic [7:0] CHAR_START   = 8'h23;
	localparam logic [7:0] CHAR_SPLIT   = 8'h2C;
	localparam logic [7:0] CHAR_STOP    = 8'h0A;
	// Hex digits, upper case
	localparam logic [7:0] CHAR_DIGIT0  = 8'h30;
	localparam logic [7:0] CHAR_ALPHA_A = 8'h41;

endpackage

`default_nettype wire

/* debug_uart.sv */
`timescale 1ns/10ps
`default_nettype none

module debug_uart #(
	parameter logic [15:0] BAUD_DIV = 16'd868
) (
	input  wire                 iCLOCK,
	input  wire                 inRESET,
	input  wire                 tx_valid,
	input  wire  [7:0]          tx_byte,
	output logic                tx_busy,
	output uart_pkg::uart_byte_t rx_byte,
	input  wire                 uart_rxd,
	output logic                uart_txd
);

	localparam logic [15:0] LAST_TICK = BAUD_DIV - 16'd1;
	localparam logic [15:0] MID_TICK  = BAUD_DIV >> 1;

	logic [9:0]  tx_shift;
	logic [15:0] tx_tick;
	logic [3:0]  tx_bit;

	logic [2:0]  rx_sync;
	logic        rx_line;
	logic        rx_active;
	logic [15:0] rx_tick;
	logic [3:0]  rx_bit;
	logic        rx_sample;
	logic [7:0]  rx_shift;
	logic        rx_valid;

	// Transmitter, stop bit and data above the start bit
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			tx_busy <= 1'b0;
			tx_tick <= '0;
			tx_bit  <= '0;
		end else if (!tx_busy) begin
			if (tx_valid) begin
				tx_busy <= 1'b1;
				tx_tick <= '0;
				tx_bit  <= '0;
			end
		end else if (tx_tick == LAST_TICK) begin
			tx_tick <= '0;
			if (tx_bit == 4'd9) begin
				tx_busy <= 1'b0;
			end else begin
				tx_bit <= tx_bit + 4'd1;
			end
		end else begin
			tx_tick <= tx_tick + 16'd1;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (tx_valid && !tx_busy) begin
			tx_shift <= {1'b1, tx_byte, 1'b0};
		end else if (tx_busy && tx_tick == LAST_TICK) begin
			tx_shift <= {1'b1, tx_shift[9:1]};
		end
	end

	assign uart_txd = tx_busy ? tx_shift[0] : 1'b1;

	// Receiver
	assign rx_line   = rx_sync[1];
	assign rx_sample = rx_active && (rx_tick == MID_TICK);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rx_sync   <= 3'b111;
			rx_active <= 1'b0;
			rx_tick   <= '0;
			rx_bit    <= '0;
			rx_valid  <= 1'b0;
		end else begin
			rx_sync  <= {rx_sync[1:0], uart_rxd};
			rx_valid <= 1'b0;
			if (!rx_active) begin
				if (rx_sync[2] && !rx_line) begin
					rx_active <= 1'b1;
					rx_tick   <= '0;
					rx_bit    <= '0;
				end
			end else begin
				if (rx_tick == LAST_TICK) begin
					rx_tick <= '0;
					rx_bit  <= rx_bit + 4'd1;
				end else begin
					rx_tick <= rx_tick + 16'd1;
				end
				if (rx_sample) begin
					// Glitch, not a real start bit
					if (rx_bit == 4'd0 && rx_line) begin
						rx_active <= 1'b0;
					end else if (rx_bit == 4'd9) begin
						rx_active <= 1'b0;
						rx_valid  <= rx_line;
					end
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (rx_sample && rx_bit >= 4'd1 && rx_bit <= 4'd8) begin
			rx_shift <= {rx_line, rx_shift[7:1]};
		end
	end

	assign rx_byte = '{valid: rx_valid, data: rx_shift};

endmodule

`default_nettype wire

/* debug_tx_format.sv */
`timescale 1ns/10ps
`default_nettype none

module debug_tx_format (
	input  wire                 iCLOCK,
	input  wire                 inRESET,
	input  wire                 fmt_req_valid,
	input  wire uart_pkg::fmt_req_t fmt_req,
	output logic                fmt_busy,
	output logic                tx_valid,
	output logic [7:0]          tx_byte,
	input  wire                 tx_busy
);

	import uart_pkg::*;

	fmt_state_e  state;
	logic [31:0] word_q;
	logic        last_q;
	logic [2:0]  nib_cnt;
	logic [3:0]  nibble;

	assign fmt_busy = (state != IDLE);
	assign tx_valid = fmt_busy && !tx_busy;
	// Most significant nibble goes out first
	assign nibble   = word_q[31:28];

	always_comb begin
		case (state)
			START: tx_byte = CHAR_START;
			HEX: begin
				if (nibble < 4'd10) begin
					tx_byte = CHAR_DIGIT0 + {4'h0, nibble};
				end else begin
					tx_byte = CHAR_ALPHA_A + {4'h0, nibble} - 8'd10;
				end
			end
			TAIL: tx_byte = last_q ? CHAR_STOP : CHAR_SPLIT;
			default: tx_byte = 8'h00;
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state   <= IDLE;
			nib_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (fmt_req_valid) begin
						state   <= fmt_req.first ? START : HEX;
						nib_cnt <= '0;
					end
				end
				START: begin
					if (tx_valid) begin
						state <= HEX;
					end
				end
				HEX: begin
					if (tx_valid) begin
						nib_cnt <= nib_cnt + 3'd1;
						if (nib_cnt == 3'd7) begin
							state <= TAIL;
						end
					end
				end
				TAIL: begin
					if (tx_valid) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (fmt_req_valid && !fmt_busy) begin
			word_q <= fmt_req.word;
			last_q <= fmt_req.last;
		end else if (state == HEX && tx_valid) begin
			word_q <= {word_q[27:0], 4'h0};
		end
	end

endmodule

`default_nettype wire

/* debug_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module debug_sequencer #(
	parameter int NUM_REGS = 37
) (
	input  wire                   iCLOCK,
	input  wire                   inRESET,
	input  wire uart_pkg::uart_byte_t rx_byte,
	output logic                  dbg_req,
	output dbg_pkg::dbg_cmd_t     dbg_cmd,
	input  wire                   dbg_busy,
	input  wire dbg_pkg::dbg_rsp_t dbg_rsp,
	output logic                  fmt_req_valid,
	output uart_pkg::fmt_req_t    fmt_req,
	input  wire                   fmt_busy
);

	import dbg_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		STOP_CORE,
		READ_ALL,
		START_CORE,
		SEND_ALL
	} seq_state_e;

	localparam logic [5:0] LAST_IDX = 6'(NUM_REGS - 1);

	seq_state_e  state;
	logic        waiting;
	logic        rx_pend;
	logic [5:0]  idx;
	logic [31:0] regs [NUM_REGS];
	logic        core_phase;
	dbg_opcode_e cmd_op;
	logic [7:0]  cmd_target;

	assign core_phase = (state == STOP_CORE) || (state == READ_ALL) || (state == START_CORE);

	// Core side
	assign dbg_req = core_phase && !waiting && !dbg_busy;

	always_comb begin
		case (state)
			STOP_CORE:  cmd_op = STOP;
			START_CORE: cmd_op = GO;
			default:    cmd_op = READ_REG;
		endcase
	end

	assign cmd_target = (state == READ_ALL) ? 8'(dbg_index_to_target(idx)) : 8'd0;
	assign dbg_cmd    = '{opcode: cmd_op, target: cmd_target, data: 32'd0};

	// Formatter side
	assign fmt_req_valid = (state == SEND_ALL) && !waiting && !fmt_busy;
	assign fmt_req       = '{word: regs[idx], first: (idx == 6'd0), last: (idx == LAST_IDX)};

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state   <= IDLE;
			waiting <= 1'b0;
			rx_pend <= 1'b0;
			idx     <= '0;
		end else begin
			// Bytes outside IDLE are dropped
			rx_pend <= rx_byte.valid && (state == IDLE);
			if (!waiting) begin
				case (state)
					IDLE: begin
						idx <= '0;
						if (rx_pend) begin
							state <= STOP_CORE;
						end
					end
					STOP_CORE, READ_ALL, START_CORE: begin
						if (!dbg_busy) begin
							waiting <= 1'b1;
						end
					end
					SEND_ALL: begin
						if (!fmt_busy) begin
							waiting <= 1'b1;
						end
					end
					default: state <= IDLE;
				endcase
			end else begin
				case (state)
					STOP_CORE: begin
						if (dbg_rsp.valid) begin
							waiting <= 1'b0;
							state   <= READ_ALL;
						end
					end
					READ_ALL: begin
						if (dbg_rsp.valid) begin
							waiting <= 1'b0;
							if (idx == LAST_IDX) begin
								idx   <= '0;
								state <= START_CORE;
							end else begin
								idx <= idx + 6'd1;
							end
						end
					end
					START_CORE: begin
						if (dbg_rsp.valid) begin
							waiting <= 1'b0;
							state   <= SEND_ALL;
						end
					end
					SEND_ALL: begin
						// Word done once the formatter drops busy
						if (!fmt_busy) begin
							waiting <= 1'b0;
							if (idx == LAST_IDX) begin
								idx   <= '0;
								state <= IDLE;
							end else begin
								idx <= idx + 6'd1;
							end
						end
					end
					default: begin
						waiting <= 1'b0;
						state   <= IDLE;
					end
				endcase
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (state == READ_ALL && waiting && dbg_rsp.valid) begin
			regs[idx] <= dbg_rsp.error ? ERROR_WORD : dbg_rsp.data;
		end
	end

endmodule

`default_nettype wire

/* debug_monitor_top.sv */
`timescale 1ns/10ps
`default_nettype none

module debug_monitor_top #(
	parameter int          NUM_REGS = 37,
	parameter logic [15:0] BAUD_DIV = 16'd868
) (
	input  wire                    iCLOCK,
	input  wire                    inRESET,
	output dbg_pkg::dbg_cmd_t      dbg_cmd,
	output logic                   dbg_req,
	input  wire                    dbg_busy,
	input  wire dbg_pkg::dbg_rsp_t dbg_rsp,
	input  wire                    uart_rxd,
	output logic                   uart_txd
);

	import uart_pkg::*;

	logic       tx_valid;
	logic [7:0] tx_byte;
	logic       tx_busy;
	uart_byte_t rx_byte;
	logic       fmt_req_valid;
	fmt_req_t   fmt_req;
	logic       fmt_busy;

	debug_uart #(
		.BAUD_DIV(BAUD_DIV)
	) u_uart (
		.iCLOCK  (iCLOCK),
		.inRESET (inRESET),
		.tx_valid(tx_valid),
		.tx_byte (tx_byte),
		.tx_busy (tx_busy),
		.rx_byte (rx_byte),
		.uart_rxd(uart_rxd),
		.uart_txd(uart_txd)
	);

	debug_tx_format u_format (
		.iCLOCK       (iCLOCK),
		.inRESET      (inRESET),
		.fmt_req_valid(fmt_req_valid),
		.fmt_req      (fmt_req),
		.fmt_busy     (fmt_busy),
		.tx_valid     (tx_valid),
		.tx_byte      (tx_byte),
		.tx_busy      (tx_busy)
	);

	debug_sequencer #(
		.NUM_REGS(NUM_REGS)
	) u_seq (
		.iCLOCK       (iCLOCK),
		.inRESET      (inRESET),
		.rx_byte      (rx_byte),
		.dbg_req      (dbg_req),
		.dbg_cmd      (dbg_cmd),
		.dbg_busy     (dbg_busy),
		.dbg_rsp      (dbg_rsp),
		.fmt_req_valid(fmt_req_valid),
		.fmt_req      (fmt_req),
		.fmt_busy     (fmt_busy)
	);

endmodule

`default_nettype wire

/* tb_debug_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_debug_monitor;

	import dbg_pkg::*;
	import uart_pkg::*;

	localparam int          NUM_REGS     = 37;
	localparam logic [15:0] BAUD_DIV     = 16'd8;
	localparam int          BIT_CYCLES   = int'(BAUD_DIV);
	localparam int          CMDS_PER_RUN = NUM_REGS + 2;
	localparam int          TIMEOUT      =
		2 * (NUM_REGS * 10 * 10 * BIT_CYCLES + NUM_REGS * 12) + 2000;

	logic        iCLOCK = 1'b0;
	logic        inRESET;
	dbg_cmd_t    dbg_cmd;
	logic        dbg_req;
	logic        dbg_busy;
	dbg_rsp_t    dbg_rsp;
	logic        uart_rxd;
	logic        uart_txd;

	logic [31:0] file_words [4 * NUM_REGS];
	logic [31:0] lfsr = 32'd66024;
	logic [7:0]  tx_chars [$];
	int          char_rd;
	int          cmd_total = 0;
	int          runs_started;
	int          cycle_count = 0;

	always #5 iCLOCK = ~iCLOCK;

	debug_monitor_top #(
		.NUM_REGS(NUM_REGS),
		.BAUD_DIV(BAUD_DIV)
	) u_dut (
		.iCLOCK  (iCLOCK),
		.inRESET (inRESET),
		.dbg_cmd (dbg_cmd),
		.dbg_req (dbg_req),
		.dbg_busy(dbg_busy),
		.dbg_rsp (dbg_rsp),
		.uart_rxd(uart_rxd),
		.uart_txd(uart_txd)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_cmd(input string name, input dbg_cmd_t exp, input dbg_cmd_t act);
		if (act !== exp) begin
			abort_run($sformatf("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act));
		end
	endtask

	task automatic check_char(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			abort_run($sformatf("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act));
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			abort_run($sformatf("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act));
		end
	endtask

	// Galois form with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [7:0] v);
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			v    = {v[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// General registers first, then the system block at 64
	function automatic logic [7:0] expected_target(input int i);
		return (i < 32) ? 8'(i) : 8'(i + 32);
	endfunction

	// Only 0-9 and A-F count
	function automatic logic is_hex_digit(input logic [7:0] c);
		return ((c >= 8'h30) && (c <= 8'h39)) || ((c >= 8'h41) && (c <= 8'h46));
	endfunction

	function automatic logic [3:0] hex_value(input logic [7:0] c);
		return (c <= 8'h39) ? 4'(c - 8'h30) : 4'(c - 8'h37);
	endfunction

	// 8N1 frame sent LSB first
	task automatic send_host_byte(input logic [7:0] b);
		logic [9:0] frame;
		int         k;
		frame = {1'b1, b, 1'b0};
		for (k = 0; k < 10; k++) begin
			@(posedge iCLOCK);
			#1;
			uart_rxd = frame[k];
			repeat (BIT_CYCLES - 1) @(posedge iCLOCK);
		end
	endtask

	task automatic next_char(output logic [7:0] c);
		while (tx_chars.size() <= char_rd) begin
			@(posedge iCLOCK);
		end
		c       = tx_chars[char_rd];
		char_rd = char_rd + 1;
	endtask

	task automatic check_text(input int run);
		logic [7:0]  c;
		logic [31:0] word;
		logic [31:0] exp_word;
		int          i;
		int          n;
		int          entry;
		next_char(c);
		check_char("uart_txd start char", CHAR_START, c);
		for (i = 0; i < NUM_REGS; i++) begin
			entry    = run * NUM_REGS + i;
			exp_word = file_words[2 * entry][0] ? ERROR_WORD : file_words[2 * entry + 1];
			word     = '0;
			for (n = 0; n < 8; n++) begin
				next_char(c);
				if (!is_hex_digit(c)) begin
					abort_run("A character of a word on uart_txd was not an upper-case hex digit");
				end
				word = {word[27:0], hex_value(c)};
			end
			check_word("uart_txd word", exp_word, word);
			next_char(c);
			check_char("uart_txd tail char", (i == NUM_REGS - 1) ? CHAR_STOP : CHAR_SPLIT, c);
		end
	endtask

	always @(posedge iCLOCK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT) begin
			abort_run("Timeout: the register dumps did not finish in time");
		end
	end

	// Core responder
	initial begin : core_model
		dbg_cmd_t   exp_cmd;
		dbg_cmd_t   held_cmd;
		logic [7:0] rnd;
		logic       outstanding;
		logic       rsp_active;
		int         rsp_wait;
		int         pos;
		int         entry;
		dbg_busy    = 1'b0;
		dbg_rsp     = '0;
		outstanding = 1'b0;
		rsp_active  = 1'b0;
		rsp_wait    = 0;
		entry       = -1;
		@(posedge inRESET);
		forever begin
			@(negedge iCLOCK);
			if (outstanding) begin
				check_cmd("dbg_cmd held", held_cmd, dbg_cmd);
			end
			if (dbg_req) begin
				if (dbg_busy) begin
					abort_run("dbg_req was raised while dbg_busy was high");
				end
				if (outstanding) begin
					abort_run("dbg_req was raised before the previous response");
				end
				if (cmd_total >= CMDS_PER_RUN * runs_started) begin
					abort_run("dbg_req was raised with no host byte pending");
				end
				pos     = cmd_total % CMDS_PER_RUN;
				entry   = -1;
				exp_cmd = '{opcode: READ_REG, target: 8'd0, data: 32'd0};
				if (pos == 0) begin
					exp_cmd.opcode = STOP;
				end else if (pos == CMDS_PER_RUN - 1) begin
					exp_cmd.opcode = GO;
				end else begin
					exp_cmd.target = expected_target(pos - 1);
					entry = (cmd_total / CMDS_PER_RUN) * NUM_REGS + pos - 1;
				end
				check_cmd("dbg_cmd", exp_cmd, dbg_cmd);
				held_cmd    = exp_cmd;
				outstanding = 1'b1;
				random_bits(3, rnd);
				rsp_wait    = int'(rnd);
				cmd_total   = cmd_total + 1;
			end
			@(posedge iCLOCK);
			#1;
			random_bits(1, rnd);
			dbg_busy = rnd[0];
			if (rsp_active) begin
				dbg_rsp     = '0;
				rsp_active  = 1'b0;
				outstanding = 1'b0;
			end else if (outstanding) begin
				if (rsp_wait == 0) begin
					if (entry >= 0) begin
						dbg_rsp = '{valid: 1'b1, error: file_words[2 * entry][0],
							data: file_words[2 * entry + 1]};
					end else begin
						dbg_rsp = '{valid: 1'b1, error: 1'b0, data: 32'd0};
					end
					rsp_active = 1'b1;
				end else begin
					rsp_wait = rsp_wait - 1;
				end
			end
		end
	end

	// Samples uart_txd at mid-bit
	initial begin : txd_decoder
		logic [7:0] c;
		int         b;
		@(posedge inRESET);
		forever begin
			@(negedge uart_txd);
			repeat (BIT_CYCLES / 2) @(negedge iCLOCK);
			if (uart_txd !== 1'b0) begin
				abort_run("Start bit on uart_txd was too short");
			end
			for (b = 0; b < 8; b++) begin
				repeat (BIT_CYCLES) @(negedge iCLOCK);
				c[b] = uart_txd;
			end
			repeat (BIT_CYCLES) @(negedge iCLOCK);
			if (uart_txd !== 1'b1) begin
				abort_run("Stop bit on uart_txd was missing");
			end
			tx_chars.push_back(c);
		end
	end

	initial begin : host
		inRESET      = 1'b0;
		uart_rxd     = 1'b1;
		char_rd      = 0;
		runs_started = 0;
		$readmemh("tb_input.txt", file_words);
		repeat (3) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		repeat (50) begin
			@(negedge iCLOCK);
			if (dbg_req !== 1'b0 || uart_txd !== 1'b1) begin
				abort_run("Outputs left their idle levels before any host byte");
			end
		end
		runs_started = 1;
		send_host_byte(8'h3F);
		check_text(0);
		if (cmd_total != CMDS_PER_RUN) begin
			abort_run("First dump issued the wrong number of debug commands");
		end
		runs_started = 2;
		send_host_byte(8'h51);
		// Extra byte while run two reads registers
		while (cmd_total < CMDS_PER_RUN + 6) begin
			@(posedge iCLOCK);
		end
		send_host_byte(8'h21);
		check_text(1);
		repeat (200) begin
			@(negedge iCLOCK);
			if (dbg_req) begin
				abort_run("dbg_req appeared after the final stop character");
			end
		end
		if (cmd_total != 2 * CMDS_PER_RUN) begin
			abort_run("Second dump issued the wrong number of debug commands");
		end
		if (tx_chars.size() != char_rd) begin
			abort_run("Extra text appeared on uart_txd after the second dump");
		end
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_input.txt */
// Error flag and read value in hex, one register read per line
// First 37 lines answer the first dump and the rest the second
0 00000000
0 12345678
0 9ABCDEF0
0 DEADBEEF
0 0BADF00D
1 5A5A5A5A
0 C001D00D
0 FEEDFACE
0 00000001
0 80000000
0 7FFFFFFF
0 A5A5A5A5
0 13579BDF
0 2468ACE0
0 0F0F0F0F
0 F0F0F0F0
0 11223344
0 55667788
0 99AABBCC
0 DDEEFF00
1 CAFEBABE
0 3C3C3C3C
0 0000FFFF
0 FFFF0000
0 01020304
0 A0B0C0D0
0 E1E2E3E4
0 4B1D0A55
0 60D5EED1
0 00C0FFEE
0 7E57C0DE
0 8BADF00D
0 4D4F4E31
1 00000BAD
0 00000200
0 0001F000
0 00FF8000
0 FFFFFFFE
0 87654321
1 12121212
0 0FEDCBA9
0 ABCDEF01
0 10000000
0 00000010
0 CCCCCCCC
0 33333333
0 E0E0E0E0
0 07070707
0 BEEFCAFE
0 4A4B4C4D
0 9E3779B9
0 6A09E667
0 BB67AE85
0 3C6EF372
0 A54FF53A
0 510E527F
0 9B05688C
0 1F83D9AB
0 5BE0CD19
0 428A2F98
0 71374491
0 B5C0FBCF
0 E9B5DBA5
0 3956C25B
0 59F111F1
0 923F82A4
0 AB1C5ED5
0 D807AA98
0 12835B01
0 243185BE
0 550C7DC3
0 72BE5D74
0 80DEB1FE
1 9BDC06A7

/* filelist.f */
dbg_pkg.sv
uart_pkg.sv
debug_uart.sv
debug_tx_format.sv
debug_sequencer.sv
debug_monitor_top.sv
tb_debug_monitor.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/10ps --top-module tb_debug_monitor \
	-f filelist.f -o tb_debug_monitor > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_debug_monitor > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Everything OK" sim.log || { echo "Simulation gave no result"; exit 1; }
echo "Simulation passed"
